/* sources.f */
+incdir+.
tl_pkg.sv
phase_timer.sv
request_front_end.sv
phase_controller.sv
lamp_driver.sv
traffic_intersection.sv
tb_traffic_intersection.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_traffic_intersection
FILELIST  = sources.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output is shown and then searched for the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_traffic_intersection.sv */
`timescale 1ns/10ps
`include "tl_macros.svh"

module tb_traffic_intersection;

    // spans seen at the lamp outputs are one tick longer than the load value
    localparam int FLASH_LEN  = `TL_FLASH_TICKS + 1;
    localparam int GREEN_LEN  = `TL_GREEN_TICKS + 1;
    localparam int YELLOW_LEN = `TL_YELLOW_TICKS + 1;
    localparam int WALK_LEN   = `TL_WALK_TICKS + 1;

    // kinds of span in the expected sequence
    localparam int SEG_FLASH     = 0;
    localparam int SEG_NS_GREEN  = 1;
    localparam int SEG_NS_YELLOW = 2;
    localparam int SEG_EW_GREEN  = 3;
    localparam int SEG_EW_YELLOW = 4;
    localparam int SEG_WALK      = 5;
    localparam int SEG_EMERG     = 6;

    localparam int ACT_NONE  = 0;
    localparam int ACT_PED   = 1;
    localparam int ACT_EMERG = 2;

    localparam int MARGIN       = 50;
    localparam int ACK_WAIT_MAX = 10;

    logic          clk;
    logic          rst_n;
    logic          emergency;
    logic          ped_req;
    tl_pkg::lamp_t ns_lamp;
    tl_pkg::lamp_t ew_lamp;
    logic          ped_walk;
    logic          ped_ack;
    logic          emergency_active;

    // stimulus rows that each point at a run of expected spans
    string row_name[$];
    int    row_act[$];
    int    row_at[$];
    int    row_arg[$];
    int    row_first[$];
    int    row_nseg[$];
    int    seg_kind[$];
    int    seg_len[$];

    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;
    bit button_busy;

    traffic_intersection u_traffic_intersection (
        .clk              (clk),
        .rst_n            (rst_n),
        .emergency        (emergency),
        .ped_req          (ped_req),
        .ns_lamp          (ns_lamp),
        .ew_lamp          (ew_lamp),
        .ped_walk         (ped_walk),
        .ped_ack          (ped_ack),
        .emergency_active (emergency_active)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = !clk;
    end

    task automatic add_row(input string name, input int act, input int at, input int arg);
        row_name.push_back(name);
        row_act.push_back(act);
        row_at.push_back(at);
        row_arg.push_back(arg);
        row_first.push_back(seg_kind.size());
        row_nseg.push_back(0);
    endtask

    task automatic add_seg(input int kind, input int len);
        seg_kind.push_back(kind);
        seg_len.push_back(len);
        row_nseg[row_nseg.size() - 1] = row_nseg[row_nseg.size() - 1] + 1;
    endtask

    task automatic build_table();
        add_row("reset and flash", ACT_NONE, 0, 0);
        add_seg(SEG_FLASH, FLASH_LEN);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        add_row("idle cycle", ACT_NONE, 0, 0);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        // walk after NS yellow and then EW green
        add_row("single request", ACT_PED, 5, 0);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_WALK, WALK_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        // two requests in one green merge into a single walk
        add_row("first of two", ACT_PED, 2, 0);
        add_seg(SEG_NS_GREEN, 15);
        add_row("second of two", ACT_PED, 1, 0);
        add_seg(SEG_NS_GREEN, GREEN_LEN - 15);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_WALK, WALK_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_row("walk after EW", ACT_PED, 2, 0);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        add_seg(SEG_WALK, 6);
        // request late in the walk so the capture lands after the latch clears
        add_row("request in walk", ACT_PED, 2, 0);
        add_seg(SEG_WALK, WALK_LEN - 6);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_WALK, WALK_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
        add_row("pending request", ACT_PED, 2, 0);
        add_seg(SEG_NS_GREEN, 20);
        // two sync cycles, one phase cycle, one lamp cycle
        add_row("emergency", ACT_EMERG, 0, 12);
        add_seg(SEG_NS_GREEN, 4);
        add_seg(SEG_EMERG, 12);
        add_seg(SEG_FLASH, FLASH_LEN);
        add_seg(SEG_NS_GREEN, GREEN_LEN);
        add_seg(SEG_NS_YELLOW, YELLOW_LEN);
        add_seg(SEG_WALK, WALK_LEN);
        add_seg(SEG_EW_GREEN, GREEN_LEN);
        add_seg(SEG_EW_YELLOW, YELLOW_LEN);
    endtask

    task automatic check_signal(input string name, input int got, input int exp);
        check_count++;
        assert (got == exp) else begin
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic check_cycle(input int kind, input int idx);
        tl_pkg::lamp_t ns_exp;
        tl_pkg::lamp_t ew_exp;
        ns_exp = tl_pkg::LAMP_RED;
        ew_exp = tl_pkg::LAMP_RED;
        case (kind)
            SEG_FLASH: begin
                // red on the first flash cycle and then off and red in turn
                ns_exp = (idx % 2 == 0) ? tl_pkg::LAMP_RED : tl_pkg::LAMP_OFF;
                ew_exp = ns_exp;
            end
            SEG_NS_GREEN:  ns_exp = tl_pkg::LAMP_GREEN;
            SEG_NS_YELLOW: ns_exp = tl_pkg::LAMP_YELLOW;
            SEG_EW_GREEN:  ew_exp = tl_pkg::LAMP_GREEN;
            SEG_EW_YELLOW: ew_exp = tl_pkg::LAMP_YELLOW;
            default: ;
        endcase
        check_signal("ns_lamp", int'(ns_lamp), int'(ns_exp));
        check_signal("ew_lamp", int'(ew_lamp), int'(ew_exp));
        check_signal("ped_walk", int'(ped_walk), (kind == SEG_WALK) ? 1 : 0);
        check_signal("emergency_active", int'(emergency_active), (kind == SEG_EMERG) ? 1 : 0);
        if (!button_busy) begin
            check_signal("ped_ack", int'(ped_ack), 0);
        end
    endtask

    // four-phase push-button exchange
    // ack latency is three rising edges each way, sampled just after each edge
    task automatic press_button();
        int wait_edges;
        int hold;
        button_busy = 1'b1;
        ped_req = 1'b1;
        wait_edges = 0;
        while (!ped_ack && wait_edges < ACK_WAIT_MAX) begin
            @(posedge clk);
            #1;
            wait_edges++;
        end
        if (!ped_ack) begin
            $display("ERROR at %0t: ped_ack never rose after ped_req went high", $time);
            error_count++;
        end else begin
            check_signal("ped_ack rise latency", wait_edges, 3);
        end
        hold = 1 + int'($urandom % 32'd4);
        repeat (hold) @(posedge clk);
        #1;
        ped_req = 1'b0;
        wait_edges = 0;
        while (ped_ack && wait_edges < ACK_WAIT_MAX) begin
            @(posedge clk);
            #1;
            wait_edges++;
        end
        if (ped_ack) begin
            $display("ERROR at %0t: ped_ack stayed high after ped_req was dropped", $time);
            error_count++;
        end else begin
            check_signal("ped_ack fall latency", wait_edges, 3);
        end
        button_busy = 1'b0;
    endtask

    task automatic pulse_emergency(input int len);
        emergency = 1'b1;
        repeat (len) @(posedge clk);
        #1;
        emergency = 1'b0;
    endtask

    task automatic apply_action(input int act, input int arg);
        case (act)
            ACT_PED: begin
                fork
                    press_button();
                join_none
            end
            ACT_EMERG: begin
                fork
                    pulse_emergency(arg);
                join_none
            end
            default: ;
        endcase
    endtask

    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int base;
        int c;
        int row_errors;
        int rows_failed;
        void'($urandom(32'he7fd_9dc7));
        rst_n       = 1'b0;
        emergency   = 1'b0;
        ped_req     = 1'b0;
        button_busy = 1'b0;
        error_count = 0;
        check_count = 0;
        rows_failed = 0;
        build_table();
        cycle_limit = MARGIN;
        foreach (seg_len[i]) begin
            cycle_limit += seg_len[i];
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        base = 1;
        for (int r = 0; r < row_act.size(); r++) begin
            row_errors = error_count;
            c = 0;
            for (int s = row_first[r]; s < row_first[r] + row_nseg[r]; s++) begin
                for (int i = 0; i < seg_len[s]; i++) begin
                    @(posedge clk);
                    #1;
                    if (c == row_at[r]) begin
                        apply_action(row_act[r], row_arg[r]);
                    end
                    // lamps are registered so mid-cycle sampling is stable
                    @(negedge clk);
                    check_cycle(seg_kind[s], i);
                    c++;
                end
            end
            if (error_count == row_errors) begin
                $display("row %0d %s, cycles %0d to %0d: ok", r, row_name[r], base, base + c - 1);
            end else begin
                $display("row %0d %s, cycles %0d to %0d: %0d errors", r, row_name[r], base,
                         base + c - 1, error_count - row_errors);
                rows_failed++;
            end
            base += c;
        end
        $display("summary: %0d rows, %0d failed, %0d checks, %0d errors",
                 row_act.size(), rows_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* traffic_intersection.sv */
`timescale 1ns/10ps

module traffic_intersection (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          emergency,
    input  logic          ped_req,
    output tl_pkg::lamp_t ns_lamp,
    output tl_pkg::lamp_t ew_lamp,
    output logic          ped_walk,
    output logic          ped_ack,
    output logic          emergency_active
);

    // front end to controller
    logic emergency_sync;
    logic ped_pending;
    logic ped_served;

    // controller and timer
    logic                timer_start;
    tl_pkg::tick_count_t timer_load;
    logic                timer_done;

    tl_pkg::phase_t phase;

    request_front_end u_request_front_end (
        .clk            (clk),
        .rst_n          (rst_n),
        .emergency      (emergency),
        .ped_req        (ped_req),
        .ped_served     (ped_served),
        .emergency_sync (emergency_sync),
        .ped_pending    (ped_pending),
        .ped_ack        (ped_ack)
    );

    phase_controller u_phase_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .emergency_sync (emergency_sync),
        .ped_pending    (ped_pending),
        .timer_done     (timer_done),
        .timer_start    (timer_start),
        .timer_load     (timer_load),
        .ped_served     (ped_served),
        .phase          (phase)
    );

    phase_timer u_phase_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (timer_start),
        .load_value (timer_load),
        .done       (timer_done)
    );

    lamp_driver u_lamp_driver (
        .clk              (clk),
        .rst_n            (rst_n),
        .phase            (phase),
        .ns_lamp          (ns_lamp),
        .ew_lamp          (ew_lamp),
        .ped_walk         (ped_walk),
        .emergency_active (emergency_active)
    );

endmodule

/* lamp_driver.sv */
`timescale 1ns/10ps

module lamp_driver (
    input  logic           clk,
    input  logic           rst_n,
    input  tl_pkg::phase_t phase,
    output tl_pkg::lamp_t  ns_lamp,
    output tl_pkg::lamp_t  ew_lamp,
    output logic           ped_walk,
    output logic           emergency_active
);

    // high on the dark half of the flash blink
    logic          blink_off;
    tl_pkg::lamp_t ns_next;
    tl_pkg::lamp_t ew_next;
    tl_pkg::lamp_t flash_code;

    // held clear outside the flash, so every flash starts on red
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blink_off <= 1'b0;
        end else if (phase == tl_pkg::PH_FLASH) begin
            blink_off <= !blink_off;
        end else begin
            blink_off <= 1'b0;
        end
    end

    assign flash_code = blink_off ? tl_pkg::LAMP_OFF : tl_pkg::LAMP_RED;

    // side that is neither green nor yellow shows red
    always_comb begin
        ns_next = tl_pkg::LAMP_RED;
        ew_next = tl_pkg::LAMP_RED;
        case (phase)
            tl_pkg::PH_FLASH: begin
                ns_next = flash_code;
                ew_next = flash_code;
            end
            tl_pkg::PH_NS_GREEN:  ns_next = tl_pkg::LAMP_GREEN;
            tl_pkg::PH_NS_YELLOW: ns_next = tl_pkg::LAMP_YELLOW;
            tl_pkg::PH_EW_GREEN:  ew_next = tl_pkg::LAMP_GREEN;
            tl_pkg::PH_EW_YELLOW: ew_next = tl_pkg::LAMP_YELLOW;
            default: begin
                ns_next = tl_pkg::LAMP_RED;
                ew_next = tl_pkg::LAMP_RED;
            end
        endcase
    end

    // output registers, one cycle behind the phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ns_lamp          <= tl_pkg::LAMP_RED;
            ew_lamp          <= tl_pkg::LAMP_RED;
            ped_walk         <= 1'b0;
            emergency_active <= 1'b0;
        end else begin
            ns_lamp          <= ns_next;
            ew_lamp          <= ew_next;
            ped_walk         <= (phase == tl_pkg::PH_WALK);
            emergency_active <= (phase == tl_pkg::PH_EMERGENCY);
        end
    end

endmodule

/* phase_controller.sv */
`timescale 1ns/10ps
`include "tl_macros.svh"

module phase_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                emergency_sync,
    input  logic                ped_pending,
    input  logic                timer_done,
    output logic                timer_start,
    output tl_pkg::tick_count_t timer_load,
    output logic                ped_served,
    output tl_pkg::phase_t      phase
);

    tl_pkg::phase_t prev_phase;
    tl_pkg::phase_t next_phase;

    // set when the walk was entered from NS yellow, so EW green is next
    logic resume_ew;
    logic next_resume_ew;

    // first cycle of the current phase
    logic phase_entry;
    // timer expiry that belongs to the current phase
    logic phase_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= tl_pkg::PH_FLASH;
            // differs from PH_FLASH so reset counts as entering the flash
            prev_phase <= tl_pkg::PH_EMERGENCY;
            resume_ew  <= 1'b0;
        end else begin
            prev_phase <= phase;
            phase      <= next_phase;
            resume_ew  <= next_resume_ew;
        end
    end

    assign phase_entry = (phase != prev_phase);

    // a count left over from a phase cut short by emergency may expire
    // in the entry cycle of the flash, that one is not ours
    assign phase_done = timer_done && !phase_entry;

    // every phase except emergency is timed from its entry cycle
    assign timer_start = phase_entry && (phase != tl_pkg::PH_EMERGENCY);

    always_comb begin
        case (phase)
            tl_pkg::PH_FLASH:     timer_load = tl_pkg::tick_count_t'(`TL_FLASH_TICKS);
            tl_pkg::PH_NS_GREEN,
            tl_pkg::PH_EW_GREEN:  timer_load = tl_pkg::tick_count_t'(`TL_GREEN_TICKS);
            tl_pkg::PH_NS_YELLOW,
            tl_pkg::PH_EW_YELLOW: timer_load = tl_pkg::tick_count_t'(`TL_YELLOW_TICKS);
            tl_pkg::PH_WALK:      timer_load = tl_pkg::tick_count_t'(`TL_WALK_TICKS);
            default:              timer_load = '0;
        endcase
    end

    // last walk cycle, unless emergency cuts the crossing short
    assign ped_served = (phase == tl_pkg::PH_WALK) && phase_done && !emergency_sync;

    always_comb begin
        next_phase     = phase;
        next_resume_ew = resume_ew;

        if (emergency_sync) begin
            // all-red override from any phase
            next_phase = tl_pkg::PH_EMERGENCY;
        end else begin
            case (phase)
                tl_pkg::PH_FLASH: begin
                    if (phase_done) begin
                        next_phase = tl_pkg::PH_NS_GREEN;
                    end
                end

                tl_pkg::PH_NS_GREEN: begin
                    if (phase_done) begin
                        next_phase = tl_pkg::PH_NS_YELLOW;
                    end
                end

                tl_pkg::PH_NS_YELLOW: begin
                    if (phase_done) begin
                        if (ped_pending) begin
                            next_phase     = tl_pkg::PH_WALK;
                            next_resume_ew = 1'b1;
                        end else begin
                            next_phase = tl_pkg::PH_EW_GREEN;
                        end
                    end
                end

                tl_pkg::PH_EW_GREEN: begin
                    if (phase_done) begin
                        next_phase = tl_pkg::PH_EW_YELLOW;
                    end
                end

                tl_pkg::PH_EW_YELLOW: begin
                    if (phase_done) begin
                        if (ped_pending) begin
                            next_phase     = tl_pkg::PH_WALK;
                            next_resume_ew = 1'b0;
                        end else begin
                            next_phase = tl_pkg::PH_NS_GREEN;
                        end
                    end
                end

                tl_pkg::PH_WALK: begin
                    // hand the green to the approach that did not just run
                    if (phase_done) begin
                        next_phase = resume_ew ? tl_pkg::PH_EW_GREEN : tl_pkg::PH_NS_GREEN;
                    end
                end

                // emergency has cleared, restart from the flash
                tl_pkg::PH_EMERGENCY: next_phase = tl_pkg::PH_FLASH;

                default: next_phase = tl_pkg::PH_FLASH;
            endcase
        end
    end

endmodule

/* request_front_end.sv */
`timescale 1ns/10ps

module request_front_end (
    input  logic clk,
    input  logic rst_n,
    input  logic emergency,
    input  logic ped_req,
    input  logic ped_served,
    output logic emergency_sync,
    output logic ped_pending,
    output logic ped_ack
);

    // first stage of each synchronizer
    logic emergency_meta;
    logic ped_meta;
    // second stage of the pedestrian synchronizer
    logic ped_sync;

    // capture a new request, only while the previous handshake has closed
    logic ped_capture;

    // two-flop synchronizers for the asynchronous field inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emergency_meta <= 1'b0;
            emergency_sync <= 1'b0;
            ped_meta       <= 1'b0;
            ped_sync       <= 1'b0;
        end else begin
            emergency_meta <= emergency;
            emergency_sync <= emergency_meta;
            ped_meta       <= ped_req;
            ped_sync       <= ped_meta;
        end
    end

    assign ped_capture = ped_sync && !ped_ack;

    // ack follows the synchronized request, so it rises on the same
    // edge that sets the latch and falls once the field drops ped_req
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ped_ack <= 1'b0;
        end else begin
            ped_ack <= ped_sync;
        end
    end

    // pending crossing latch
    // a capture wins over the clear so a request landing on the
    // last walk cycle is not lost, repeated captures just merge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ped_pending <= 1'b0;
        end else if (ped_capture) begin
            ped_pending <= 1'b1;
        end else if (ped_served) begin
            ped_pending <= 1'b0;
        end
    end

endmodule

/* phase_timer.sv */
`timescale 1ns/10ps

module phase_timer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  tl_pkg::tick_count_t load_value,
    output logic                done
);

    // ticks left in the running phase
    tl_pkg::tick_count_t count;

    // count reaches one in the Lth cycle after the load edge
    // and that cycle is the last one of the phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            // a start while counting simply reloads
            count <= load_value;
        end else if (count != '0) begin
            count <= count - tl_pkg::tick_count_t'(1);
        end
    end

    // combinational so the controller can leave the phase on the same edge
    assign done = (count == tl_pkg::tick_count_t'(1));

endmodule

/* tl_pkg.sv */
`include "tl_macros.svh"

package tl_pkg;

    // load value handed from the controller to the timer
    typedef logic [`TL_TIMER_WIDTH-1:0] tick_count_t;

    // controller phases, in the order of the normal cycle
    typedef enum logic [2:0] {
        PH_FLASH     = 3'd0,
        PH_NS_GREEN  = 3'd1,
        PH_NS_YELLOW = 3'd2,
        PH_EW_GREEN  = 3'd3,
        PH_EW_YELLOW = 3'd4,
        PH_WALK      = 3'd5,
        PH_EMERGENCY = 3'd6
    } phase_t;

    // code driven onto one signal head
    typedef logic [1:0] lamp_t;

    localparam lamp_t LAMP_RED    = 2'd0;
    localparam lamp_t LAMP_YELLOW = 2'd1;
    localparam lamp_t LAMP_GREEN  = 2'd2;
    // dark head, used for the off half of the flash blink
    localparam lamp_t LAMP_OFF    = 2'd3;

endpackage

/* tl_macros.svh */
`ifndef TL_MACROS_SVH
`define TL_MACROS_SVH

// width of the phase tick counter and of every load value
`define TL_TIMER_WIDTH 8

// phase load values in ticks
// a timed phase lasts one tick longer than its load value
// because the load happens in the first cycle of the phase

// start-up flash, both heads blinking red
`define TL_FLASH_TICKS 5

// green on either approach
`define TL_GREEN_TICKS 30

// yellow clearance on either approach
`define TL_YELLOW_TICKS 5

// pedestrian walk with all vehicle heads red
`define TL_WALK_TICKS 10

`endif
